// ==== Bender.yml ====
package:
  name: prefetch

sources:
  # design, packages first
  - rtl/mem_pkg.sv
  - rtl/axi3_pkg.sv
  - rtl/stream_buffer.sv
  - rtl/prefetch_ctrl.sv
  - rtl/prefetch_top.sv

  # verification only
  - target: test
    files:
      - verif/axi3_rd_slave.sv
      - verif/prefetch_chk.sv
      - verif/prefetch_tb.sv

// ==== rtl/axi3_pkg.sv ====
// AXI3 read channel package with request/response structs, burst and size encodings
`default_nettype none

package axi3_pkg;

	import mem_pkg::*;

	// field widths of the AXI3 read channels
	localparam int AXI_ID_WIDTH   = 4;
	localparam int AXI_LEN_WIDTH  = 4;
	localparam int AXI_RESP_WIDTH = 2;

	typedef logic [AXI_ID_WIDTH-1:0]   axi_id_t;
	typedef logic [AXI_LEN_WIDTH-1:0]  axi_len_t;
	typedef logic [AXI_RESP_WIDTH-1:0] axi_resp_t;

	// ids 0 and 1 are taken by the icache and dcache
	localparam axi_id_t PREFETCH_ARID = axi_id_t'(2);

	// one line per burst, arlen counts beats minus one
	localparam axi_len_t LINE_ARLEN = axi_len_t'(LINE_WORDS - 1);

	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} burst_e;

	// bytes per beat, encoded as log2
	typedef enum logic [2:0] {
		SIZE_1B   = 3'b000,
		SIZE_2B   = 3'b001,
		SIZE_4B   = 3'b010,
		SIZE_8B   = 3'b011,
		SIZE_16B  = 3'b100,
		SIZE_32B  = 3'b101,
		SIZE_64B  = 3'b110,
		SIZE_128B = 3'b111
	} size_e;

	// master to slave, address channel plus rready
	typedef struct packed {
		axi_id_t  arid;
		phys_t    araddr;
		axi_len_t arlen;
		size_e    arsize;
		burst_e   arburst;
		logic     arvalid;
		logic     rready;
	} axi3_rd_req_t;

	// slave to master, arready plus the read data channel
	typedef struct packed {
		logic      arready;
		axi_id_t   rid;
		word_t     rdata;
		axi_resp_t rresp;
		logic      rlast;
		logic      rvalid;
	} axi3_rd_resp_t;

endpackage

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
// cache-side memory package with address, line label and cache line types
`default_nettype none

package mem_pkg;

	// physical address space
	localparam int PHYS_WIDTH = 32;

	// one cache line, fetched as a single burst of bus words
	localparam int LINE_WIDTH = 256;
	localparam int WORD_WIDTH = 32;
	localparam int LINE_WORDS = LINE_WIDTH / WORD_WIDTH;

	// byte offset inside a line, dropped to form the label
	localparam int LINE_OFFSET = $clog2(LINE_WIDTH / 8);

	// label is tag plus index
	localparam int LABEL_WIDTH = PHYS_WIDTH - LINE_OFFSET;

	// selects one word of a line, also the width of the beat counter
	localparam int WORD_SEL_WIDTH = $clog2(LINE_WORDS);

	typedef logic [PHYS_WIDTH-1:0] phys_t;

	typedef logic [LABEL_WIDTH-1:0] label_t;

	typedef logic [WORD_WIDTH-1:0] word_t;

	typedef logic [WORD_SEL_WIDTH-1:0] word_sel_t;

	// word 0 sits in the low bits and holds the lowest address
	typedef word_t [LINE_WORDS-1:0] line_t;

	// first byte address of a labelled line
	function automatic phys_t label_to_addr(input label_t label);
		phys_t addr;
		addr = {label, {LINE_OFFSET{1'b0}}};
		return addr;
	endfunction

	// label of the line that follows in memory
	function automatic label_t next_label(input label_t label);
		label_t nxt;
		nxt = label + label_t'(1);
		return nxt;
	endfunction

endpackage

`default_nettype wire

// ==== rtl/prefetch_ctrl.sv ====
// prefetch controller that checks misses against the stream buffer and queues the next fetch
`default_nettype none

module prefetch_ctrl
	import mem_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	// miss from the data cache
	input  logic   miss_vld,
	input  label_t miss_label,
	// hit answer, one cycle after the miss
	output logic   hit,
	output line_t  hit_data,
	// pending prefetch towards the stream buffer
	output label_t req_label,
	output logic   req_vld,
	input  logic   accept,
	// current contents of the stream buffer
	input  label_t buf_label,
	input  line_t  buf_line,
	input  logic   buf_vld
);

	// hit decision for the miss seen this cycle
	logic hit_n;

	assign hit_n = miss_vld && buf_vld && (buf_label == miss_label);

	// hit pulse and pending flag
	always_ff @(posedge clk) begin
		if (rst) begin
			hit     <= 1'b0;
			req_vld <= 1'b0;
		end else begin
			hit <= hit_n;
			// a new miss wins over an accept in the same cycle
			if (miss_vld) begin
				req_vld <= 1'b1;
			end else if (accept) begin
				req_vld <= 1'b0;
			end
		end
	end

	// newest miss label replaces any older pending one
	always_ff @(posedge clk) begin
		if (miss_vld) begin
			req_label <= miss_label;
		end
	end

	// line captured together with the hit
	always_ff @(posedge clk) begin
		if (hit_n) begin
			hit_data <= buf_line;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/prefetch_top.sv ====
// next-line prefetch top that joins the prefetch controller and the stream buffer
`default_nettype none

module prefetch_top
	import mem_pkg::*, axi3_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	// data cache side
	input  logic          miss_vld,
	input  label_t        miss_label,
	output logic          hit,
	output line_t         hit_data,
	// AXI3 read port
	output axi3_rd_req_t  axi_req,
	input  axi3_rd_resp_t axi_resp
);

	// controller to buffer
	label_t req_label;
	logic   req_vld;
	logic   accept;

	// buffer to controller
	label_t buf_label;
	line_t  buf_line;
	logic   buf_vld;

	prefetch_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.miss_vld   (miss_vld),
		.miss_label (miss_label),
		.hit        (hit),
		.hit_data   (hit_data),
		.req_label  (req_label),
		.req_vld    (req_vld),
		.accept     (accept),
		.buf_label  (buf_label),
		.buf_line   (buf_line),
		.buf_vld    (buf_vld)
	);

	stream_buffer u_sbuf (
		.clk       (clk),
		.rst       (rst),
		.req_label (req_label),
		.req_vld   (req_vld),
		.accept    (accept),
		.axi_req   (axi_req),
		.axi_resp  (axi_resp),
		.buf_label (buf_label),
		.buf_line  (buf_line),
		.buf_vld   (buf_vld)
	);

endmodule

`default_nettype wire

// ==== rtl/stream_buffer.sv ====
// stream buffer that fetches the line after a requested label over AXI3 and holds it
`default_nettype none

module stream_buffer
	import mem_pkg::*, axi3_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	// prefetch request from the controller
	input  label_t        req_label,
	input  logic          req_vld,
	output logic          accept,
	// AXI3 read master port
	output axi3_rd_req_t  axi_req,
	input  axi3_rd_resp_t axi_resp,
	// buffered line
	output label_t        buf_label,
	output line_t         buf_line,
	output logic          buf_vld
);

	typedef enum logic [1:0] {
		IDLE,
		WAIT_AXI_READY,
		RECEIVING,
		FINISH
	} sb_state_e;

	sb_state_e state;
	sb_state_e state_n;

	word_sel_t burst_cnt;
	word_sel_t burst_cnt_n;

	label_t label_r;
	line_t  line_r;
	logic   vld_r;

	// one data beat taken this cycle
	logic beat;
	logic last_beat;

	// a request is only taken while no burst is in flight
	assign accept = req_vld && ((state == IDLE) || (state == FINISH));

	assign beat      = (state == RECEIVING) && axi_resp.rvalid;
	assign last_beat = beat && axi_resp.rlast;

	assign buf_label = label_r;
	assign buf_line  = line_r;
	assign buf_vld   = vld_r;

	// next state
	always_comb begin
		state_n = state;
		unique case (state)
			IDLE, FINISH: begin
				if (req_vld) begin
					state_n = WAIT_AXI_READY;
				end else begin
					state_n = IDLE;
				end
			end
			WAIT_AXI_READY: begin
				if (axi_resp.arready) begin
					state_n = RECEIVING;
				end
			end
			RECEIVING: begin
				if (last_beat) begin
					state_n = FINISH;
				end
			end
		endcase
	end

	// beat counter restarts with every address phase
	always_comb begin
		burst_cnt_n = burst_cnt;
		if (state == WAIT_AXI_READY) begin
			burst_cnt_n = '0;
		end else if (beat) begin
			burst_cnt_n = burst_cnt + word_sel_t'(1);
		end
	end

	// fixed burst shape, only valid and address depend on state
	always_comb begin
		axi_req         = '0;
		axi_req.arid    = PREFETCH_ARID;
		axi_req.arlen   = LINE_ARLEN;
		axi_req.arsize  = SIZE_4B;
		axi_req.arburst = BURST_INCR;
		if (state == WAIT_AXI_READY) begin
			axi_req.arvalid = 1'b1;
			axi_req.araddr  = label_to_addr(label_r);
		end
		// rvalid gaps simply stall the counter
		axi_req.rready = beat;
	end

	// control state
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			burst_cnt <= '0;
			vld_r     <= 1'b0;
		end else begin
			state     <= state_n;
			burst_cnt <= burst_cnt_n;
			if (last_beat) begin
				vld_r <= 1'b1;
			end else if (accept) begin
				// old line stays visible for the accept cycle itself
				vld_r <= 1'b0;
			end
		end
	end

	// label of the line being fetched, one past the requested one
	always_ff @(posedge clk) begin
		if (accept) begin
			label_r <= next_label(req_label);
		end
	end

	// INCR burst, so beat n lands in word n
	always_ff @(posedge clk) begin
		if (beat) begin
			line_r[burst_cnt] <= axi_resp.rdata;
		end
	end

endmodule

`default_nettype wire

// ==== verif/axi3_rd_slave.sv ====
// AXI3 read memory model with random handshake gaps and data derived from the address
`default_nettype none

module axi3_rd_slave
	import mem_pkg::*, axi3_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	// fresh random bits every cycle, used for gap lengths
	input  logic [31:0]   rnd,
	input  axi3_rd_req_t  axi_req,
	output axi3_rd_resp_t axi_resp
);

	logic       busy;
	logic [1:0] ar_gap;
	logic [1:0] r_gap;
	phys_t      addr;
	axi_id_t    id;
	axi_len_t   beat;
	axi_len_t   len;

	// memory contents, a fixed mix of the byte address
	function automatic word_t mem_word(input phys_t a);
		phys_t x;
		x = a ^ 32'h9e37_79b9;
		return {x[24:0], x[31:25]};
	endfunction

	always_comb begin
		axi_resp         = '0;
		axi_resp.arready = !busy && (ar_gap == 2'd0);
		axi_resp.rvalid  = busy && (r_gap == 2'd0);
		axi_resp.rid     = id;
		axi_resp.rdata   = mem_word(addr);
		axi_resp.rlast   = axi_resp.rvalid && (beat == len);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy   <= 1'b0;
			ar_gap <= 2'd0;
			r_gap  <= 2'd0;
			addr   <= '0;
			id     <= '0;
			beat   <= '0;
			len    <= '0;
		end else if (!busy) begin
			if (ar_gap != 2'd0) begin
				ar_gap <= ar_gap - 2'd1;
			end else if (axi_req.arvalid) begin
				busy  <= 1'b1;
				addr  <= axi_req.araddr;
				id    <= axi_req.arid;
				len   <= axi_req.arlen;
				beat  <= '0;
				r_gap <= rnd[31:30];
			end
		end else begin
			if (r_gap != 2'd0) begin
				r_gap <= r_gap - 2'd1;
			end else if (axi_req.rready) begin
				// INCR burst of 4-byte beats
				addr  <= addr + phys_t'(4);
				beat  <= beat + axi_len_t'(1);
				r_gap <= rnd[29:28];
				if (beat == len) begin
					busy   <= 1'b0;
					ar_gap <= rnd[27:26];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/prefetch_chk.sv ====
// protocol checker for the AXI3 read port and the hit pulse of the prefetcher
`default_nettype none

module prefetch_chk
	import mem_pkg::*, axi3_pkg::*;
(
	input logic          clk,
	input logic          rst,
	input logic          miss_vld,
	input logic          hit,
	input axi3_rd_req_t  axi_req,
	input axi3_rd_resp_t axi_resp
);

	// number of assertion failures so far
	int fail_count = 0;

	a_ar_hold: assert property (@(posedge clk) disable iff (rst)
		axi_req.arvalid && !axi_resp.arready |=>
			axi_req.arvalid && $stable(axi_req.araddr))
	else begin
		fail_count++;
		$error("arvalid dropped or araddr changed before arready");
	end

	a_rready: assert property (@(posedge clk) disable iff (rst)
		axi_req.rready |-> axi_resp.rvalid)
	else begin
		fail_count++;
		$error("rready high without rvalid");
	end

	// a second hit needs a miss in between
	a_hit_pulse: assert property (@(posedge clk) disable iff (rst)
		hit |=> !hit || $past(miss_vld))
	else begin
		fail_count++;
		$error("hit held for two cycles without a new miss");
	end

endmodule

bind prefetch_top prefetch_chk u_chk (
	.clk      (clk),
	.rst      (rst),
	.miss_vld (miss_vld),
	.hit      (hit),
	.axi_req  (axi_req),
	.axi_resp (axi_resp)
);

`default_nettype wire

// ==== verif/prefetch_tb.sv ====
// testbench for the next-line prefetcher with a random miss stream and a cycle model
`default_nettype none

module prefetch_tb
	import mem_pkg::*, axi3_pkg::*;
();

	localparam int CLK_PERIOD      = 4;
	localparam int RESET_CYCLES    = 8;
	localparam int SETTLE_CYCLES   = 80;
	localparam int DIR_ROUNDS      = 6;
	localparam int BURSTS          = 8;
	localparam int BURST_MISSES    = 6;
	localparam int TOTAL_MISSES    = 3 * DIR_ROUNDS + BURSTS * BURST_MISSES;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 100 * TOTAL_MISSES + 200;
	localparam logic [31:0] SEED   = 32'he8bda791;

	logic          clk;
	logic          rst;
	logic          miss_vld;
	label_t        miss_label;
	logic          hit;
	line_t         hit_data;
	axi3_rd_req_t  axi_req;
	axi3_rd_resp_t axi_resp;

	logic [31:0] gap_rnd;
	logic [31:0] stim_state;
	int          errors;

	// model state, mirrors the pending request and the buffer
	logic   pend_vld;
	label_t pend_label;
	logic   busy;
	logic   ar_due;
	logic   recv;
	label_t fetch_label;
	logic   mbuf_vld;
	label_t mbuf_label;
	logic   exp_hit;
	label_t exp_label;
	label_t fetched[$];

	prefetch_top UUT (
		.clk        (clk),
		.rst        (rst),
		.miss_vld   (miss_vld),
		.miss_label (miss_label),
		.hit        (hit),
		.hit_data   (hit_data),
		.axi_req    (axi_req),
		.axi_resp   (axi_resp)
	);

	axi3_rd_slave u_mem (
		.clk      (clk),
		.rst      (rst),
		.rnd      (gap_rnd),
		.axi_req  (axi_req),
		.axi_resp (axi_resp)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic phys_t mem_word(input phys_t a);
		phys_t x;
		x = a ^ 32'h9e37_79b9;
		return {x[24:0], x[31:25]};
	endfunction

	// expected line, word 0 at the line base
	function automatic line_t model_line(input label_t label);
		line_t line;
		phys_t base;
		base = {label, 5'b0};
		for (int i = 0; i < 8; i++) begin
			line[i] = mem_word(base + phys_t'(4 * i));
		end
		return line;
	endfunction

	task automatic check_val(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error: %s is %h, expected %h", name, got, exp);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic draw_random(output logic [31:0] val);
		stim_state = lcg_next(stim_state);
		val = stim_state;
	endtask

	// called just after a rising edge, returns just after the next one
	task automatic send_miss(input label_t label);
		miss_vld   = 1'b1;
		miss_label = label;
		@(posedge clk);
		#1;
		miss_vld = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// new gap bits for the memory every cycle
	always @(posedge clk) begin
		#1;
		gap_rnd = lcg_next(gap_rnd);
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: no end of test after %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$fatal(1);
	end

	always @(posedge clk) begin
		if (UUT.u_chk.fail_count != 0) begin
			$display("Error: a protocol assertion failed in the checker");
			$display("Simulation FAILED");
			$fatal(1);
		end
	end

	// cycle model, sampled mid-cycle where everything is stable
	always @(negedge clk) begin
		logic accept_m;
		logic found;
		if (rst) begin
			pend_vld = 1'b0;
			busy     = 1'b0;
			ar_due   = 1'b0;
			recv     = 1'b0;
			mbuf_vld = 1'b0;
			exp_hit  = 1'b0;
		end else begin
			check_val("hit", hit, exp_hit);
			if (exp_hit) begin
				check_val("hit_data", hit_data, model_line(exp_label));
				found = 1'b0;
				foreach (fetched[i]) begin
					if (fetched[i] == exp_label) begin
						found = 1'b1;
					end
				end
				check_val("hit_label_fetched", found, 1'b1);
			end
			check_val("arvalid", axi_req.arvalid, ar_due);
			// data is taken only while the burst is in flight
			check_val("rready", axi_req.rready, recv && axi_resp.rvalid);
			if (axi_req.arvalid && axi_resp.arready) begin
				check_val("arid", axi_req.arid, 4'd2);
				check_val("arlen", axi_req.arlen, 4'd7);
				check_val("arburst", axi_req.arburst, 2'b01);
				check_val("arsize", axi_req.arsize, 3'b010);
				check_val("araddr", axi_req.araddr, {fetch_label, 5'b0});
				fetched.push_back(fetch_label);
				ar_due = 1'b0;
				recv   = 1'b1;
			end
			exp_hit   = miss_vld && mbuf_vld && (mbuf_label == miss_label);
			exp_label = miss_label;
			accept_m  = pend_vld && !busy;
			if (recv && axi_resp.rvalid && axi_resp.rlast) begin
				recv       = 1'b0;
				busy       = 1'b0;
				mbuf_vld   = 1'b1;
				mbuf_label = fetch_label;
			end
			if (accept_m) begin
				fetch_label = pend_label + label_t'(1);
				busy        = 1'b1;
				ar_due      = 1'b1;
				mbuf_vld    = 1'b0;
			end
			// newest miss replaces the pending label
			if (miss_vld) begin
				pend_vld   = 1'b1;
				pend_label = miss_label;
			end else if (accept_m) begin
				pend_vld = 1'b0;
			end
		end
	end

	initial begin
		label_t      base;
		logic [31:0] rnd;
		rst        = 1'b1;
		miss_vld   = 1'b0;
		miss_label = '0;
		errors     = 0;
		gap_rnd    = SEED;
		stim_state = lcg_next(SEED);
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// quiet until the first miss
		repeat (20) begin
			@(posedge clk);
			#1;
			check_val("hit", hit, 1'b0);
			check_val("arvalid", axi_req.arvalid, 1'b0);
		end

		// settled miss, then next line hits and an unrelated line does not
		for (int r = 0; r < DIR_ROUNDS; r++) begin
			draw_random(rnd);
			base = rnd[31:5];
			send_miss(base);
			idle(SETTLE_CYCLES);
			send_miss(base + label_t'(1));
			check_val("hit", hit, 1'b1);
			check_val("hit_data", hit_data, model_line(base + label_t'(1)));
			idle(SETTLE_CYCLES);
			// buffer holds base + 2 here
			send_miss(base + label_t'(5));
			check_val("hit", hit, 1'b0);
			idle(SETTLE_CYCLES);
		end

		// random misses in a small window around a base label
		for (int b = 0; b < BURSTS; b++) begin
			draw_random(rnd);
			base = rnd[31:5];
			for (int m = 0; m < BURST_MISSES; m++) begin
				draw_random(rnd);
				send_miss(base + label_t'(rnd[31:30]));
				idle(int'(rnd[29:26]));
			end
			idle(SETTLE_CYCLES);
		end

		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/mem_pkg.sv
rtl/axi3_pkg.sv
rtl/stream_buffer.sv
rtl/prefetch_ctrl.sv
rtl/prefetch_top.sv
verif/axi3_rd_slave.sv
verif/prefetch_chk.sv
verif/prefetch_tb.sv
